/* tb.f */
+incdir+bench
verilog/rename_pkg.sv
verilog/rob_tag_alloc.sv
verilog/reg_source_table.sv
verilog/reg_valid_tracker.sv
verilog/operand_ready.sv
verilog/rename_status_top.sv
bench/rename_status_tb.sv

/* Bender.yml */
package:
  name: rename_status

sources:
  - files:
      - verilog/rename_pkg.sv
      - verilog/rob_tag_alloc.sv
      - verilog/reg_source_table.sv
      - verilog/reg_valid_tracker.sv
      - verilog/operand_ready.sv
      - verilog/rename_status_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/rename_status_tb.sv

/* bench/rename_status_checks.svh */
// scoreboard reference checks

`ifndef RENAME_STATUS_CHECKS_SVH
`define RENAME_STATUS_CHECKS_SVH

// ========================================
// compare tasks
// ========================================

task automatic check_vec(input string name, input reg_vec_t exp, input reg_vec_t act);
	if (act !== exp) begin
		$display("[FAIL] %s expected %h actual %h", name, exp, act);
		abort_run();
	end
endtask

task automatic check_tags(input string name, input slot_tags_t exp, input slot_tags_t act);
	if (act !== exp) begin
		$display("[FAIL] %s expected %h actual %h", name, exp, act);
		abort_run();
	end
endtask

task automatic check_ready(input string name, input logic [QSLOTS-1:0] exp,
		input logic [QSLOTS-1:0] act);
	if (act !== exp) begin
		$display("[FAIL] %s expected %b actual %b", name, exp, act);
		abort_run();
	end
endtask

// ========================================
// reference model
// ========================================

// model state, one entry per register plus the status register at AREGS
reg_vec_t m_valid;
rob_tag_t m_tag [AREGS+1];
logic     m_pend [AREGS+1];
int       m_tail;

task automatic model_reset();
	m_valid = '1;
	m_tail = 0;
	for (int r = 0; r <= AREGS; r++) begin
		m_tag[r] = '0;
		m_pend[r] = 1'b0;
	end
endtask

// valid slots count up from the tail in slot order, idle slots repeat the next tag
function automatic slot_tags_t model_tags(input slot_req_t [QSLOTS-1:0] s);
	slot_tags_t t;
	int n;
	n = 0;
	for (int i = 0; i < QSLOTS; i++) begin
		t[i] = rob_tag_t'((m_tail + n) % RENTRIES);
		n = n + int'(s[i].valid);
	end
	return t;
endfunction

// the advanced vector is the next state before any queue term is applied
// a commit on an invalid register is decided by the recorded producer alone
function automatic reg_vec_t model_adv(input commit_t [CSLOTS-1:0] c, input logic bm,
		input reg_vec_t live);
	reg_vec_t v;
	v = m_valid;
	for (int r = 0; r <= AREGS; r++) begin
		if (bm && !live[r]) begin
			v[r] = 1'b1;
		end
	end
	for (int p = 0; p < CSLOTS; p++) begin
		if (c[p].valid && c[p].rfw && !m_valid[c[p].tgt]) begin
			v[c[p].tgt] = m_pend[c[p].tgt] && (m_tag[c[p].tgt] == c[p].tag);
		end
		if (c[p].valid && c[p].srw && !m_valid[AREGS]) begin
			v[AREGS] = m_pend[AREGS] && (m_tag[AREGS] == c[p].tag);
		end
	end
	return v;
endfunction

function automatic logic [QSLOTS-1:0] model_ready(input slot_src_t [QSLOTS-1:0] s,
		input reg_vec_t adv);
	logic [QSLOTS-1:0] r;
	for (int i = 0; i < QSLOTS; i++) begin
		r[i] = (s[i].rs1 == 0 || adv[s[i].rs1]) && (s[i].rs2 == 0 || adv[s[i].rs2]);
	end
	return r;
endfunction

// state change at the clock edge, queued producers win over same-cycle commits
task automatic model_edge(input slot_req_t [QSLOTS-1:0] s, input commit_t [CSLOTS-1:0] c,
		input logic bm, input reg_vec_t live);
	reg_vec_t nxt;
	rob_tag_t tag;
	int n;
	nxt = model_adv(c, bm, live);
	n = 0;
	if (!bm) begin
		for (int i = 0; i < QSLOTS; i++) begin
			if (s[i].valid) begin
				tag = rob_tag_t'((m_tail + n) % RENTRIES);
				n++;
				if (s[i].rfw) begin
					nxt[s[i].rd] = 1'b0;
					m_tag[s[i].rd] = tag;
					m_pend[s[i].rd] = 1'b1;
				end
				if (s[i].srw) begin
					nxt[AREGS] = 1'b0;
					m_tag[AREGS] = tag;
					m_pend[AREGS] = 1'b1;
				end
			end
		end
		m_tail = (m_tail + n) % RENTRIES;
	end
	m_valid = nxt;
endtask

`endif

/* bench/rename_status_tb.sv */
// rename status testbench

`timescale 1ns/1ps

module rename_status_tb import rename_pkg::*; ();

	localparam int CLK_PERIOD = 10;
	localparam int RAND_CYCLES = 200;

	// a table row holds its stimulus and the outputs expected before its clock edge
	typedef struct packed {
		slot_req_t [QSLOTS-1:0] slots;
		slot_src_t [QSLOTS-1:0] srcs;
		commit_t   [CSLOTS-1:0] commits;
		logic                   bm;
		reg_vec_t               live;
		reg_vec_t               exp_valid;
		reg_vec_t               exp_adv;
		slot_tags_t             exp_tags;
		logic      [QSLOTS-1:0] exp_ready;
	} row_t;

	localparam reg_vec_t ALLV = '1;
	localparam commit_t NC = '0;
	localparam slot_req_t IDLE = '0;

	logic clk;
	logic rst;
	slot_req_t [QSLOTS-1:0] slots;
	slot_src_t [QSLOTS-1:0] srcs;
	commit_t [CSLOTS-1:0] commits;
	logic branchmiss;
	reg_vec_t livetarget;
	slot_tags_t slot_tags;
	reg_vec_t reg_valid;
	reg_vec_t reg_is_valid;
	logic [QSLOTS-1:0] ops_ready;

	row_t rows[$];
	string names[$];
	logic [15:0] lfsr_state;

	rename_status_top rename_status_top_inst (
		.clk          (clk),
		.rst          (rst),
		.slots        (slots),
		.srcs         (srcs),
		.commits      (commits),
		.branchmiss   (branchmiss),
		.livetarget   (livetarget),
		.slot_tags    (slot_tags),
		.reg_valid    (reg_valid),
		.reg_is_valid (reg_is_valid),
		.ops_ready    (ops_ready)
	);

	task automatic abort_run();
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	`include "rename_status_checks.svh"

	// ========================================
	// stimulus helpers
	// ========================================

	function automatic slot_req_t qs(input logic rfw, input logic srw, input int rd);
		return '{valid: 1'b1, rfw: rfw, srw: srw, rd: reg_idx_t'(rd)};
	endfunction

	function automatic slot_src_t sr(input int a, input int b);
		return '{rs1: reg_idx_t'(a), rs2: reg_idx_t'(b)};
	endfunction

	function automatic commit_t cm(input int tag, input logic rfw, input logic srw,
			input int tgt);
		return '{valid: 1'b1, tag: rob_tag_t'(tag), rfw: rfw, srw: srw,
			tgt: reg_idx_t'(tgt)};
	endfunction

	function automatic reg_vec_t bit_of(input int r);
		return reg_vec_t'(1) << r;
	endfunction

	task automatic add_row(input string name, input slot_req_t [QSLOTS-1:0] s,
			input slot_src_t [QSLOTS-1:0] src, input commit_t [CSLOTS-1:0] c, input logic bm,
			input reg_vec_t live, input reg_vec_t ev, input reg_vec_t ea, input slot_tags_t et,
			input logic [QSLOTS-1:0] er);
		rows.push_back('{s, src, c, bm, live, ev, ea, et, er});
		names.push_back(name);
	endtask

	// Galois LFSR on x^16 + x^14 + x^13 + x^11 + 1 that steps once for each bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		logic lsb;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lsb = lfsr_state[0];
			lfsr_state = lfsr_state >> 1;
			if (lsb) begin
				lfsr_state = lfsr_state ^ 16'hB400;
			end
			v = {v[30:0], lsb};
		end
		return v;
	endfunction

	// compares every output against the row's expectations before the edge
	task automatic check_outputs(input string name, input row_t r);
		check_vec({name, " reg_valid"}, r.exp_valid, reg_valid);
		check_vec({name, " reg_is_valid"}, r.exp_adv, reg_is_valid);
		check_tags({name, " slot_tags"}, r.exp_tags, slot_tags);
		check_ready({name, " ops_ready"}, r.exp_ready, ops_ready);
	endtask

	task automatic drive_row(input row_t r);
		slots = r.slots;
		srcs = r.srcs;
		commits = r.commits;
		branchmiss = r.bm;
		livetarget = r.live;
	endtask

	// ========================================
	// clock and watchdog
	// ========================================

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// the table is filled at time zero, so its length is known after the first step
	initial begin
		int limit;
		#1;
		limit = (rows.size() + RAND_CYCLES + 10) * CLK_PERIOD;
		#(limit);
		$display("timeout: the run did not finish within %0d ns", limit);
		abort_run();
	end

	// ========================================
	// main sequence
	// ========================================

	initial begin
		row_t r;
		rst = 1'b1;
		drive_row('0);
		lfsr_state = 16'd17746;
		model_reset();

		// tags 0..2 come from reset and r5, r6 and the status register then wait on them
		add_row("reset tags", {qs(0, 1, 0), qs(1, 0, 6), qs(1, 0, 5)},
			{sr(7, 1), sr(0, 0), sr(5, 6)}, {NC, NC, NC}, 1'b0, '0,
			ALLV, ALLV, {3'd2, 3'd1, 3'd0}, 3'b111);
		add_row("queued clear", {IDLE, IDLE, IDLE}, {sr(0, 0), sr(6, 1), sr(5, 0)},
			{NC, NC, NC}, 1'b0, '0, ~(bit_of(5) | bit_of(6) | bit_of(32)),
			~(bit_of(5) | bit_of(6) | bit_of(32)), {3'd3, 3'd3, 3'd3}, 3'b100);
		add_row("commit wakeup", {IDLE, IDLE, IDLE}, {sr(0, 5), sr(6, 0), sr(5, 0)},
			{NC, NC, cm(0, 1, 0, 5)}, 1'b0, '0, ~(bit_of(5) | bit_of(6) | bit_of(32)),
			~(bit_of(6) | bit_of(32)), {3'd3, 3'd3, 3'd3}, 3'b101);
		// r9 is written by tag 3 and then tag 4 in the same cycle
		add_row("two writers", {IDLE, qs(1, 0, 9), qs(1, 0, 9)}, '0,
			{NC, NC, NC}, 1'b0, '0, ~(bit_of(6) | bit_of(32)),
			~(bit_of(6) | bit_of(32)), {3'd5, 3'd4, 3'd3}, 3'b111);
		add_row("older commit", {IDLE, IDLE, IDLE}, {sr(0, 0), sr(0, 0), sr(9, 0)},
			{NC, NC, cm(3, 1, 0, 9)}, 1'b0, '0, ~(bit_of(6) | bit_of(9) | bit_of(32)),
			~(bit_of(6) | bit_of(9) | bit_of(32)), {3'd5, 3'd5, 3'd5}, 3'b110);
		add_row("newer commit", {IDLE, IDLE, IDLE}, {sr(0, 0), sr(0, 0), sr(9, 9)},
			{NC, NC, cm(4, 1, 0, 9)}, 1'b0, '0, ~(bit_of(6) | bit_of(9) | bit_of(32)),
			~(bit_of(6) | bit_of(32)), {3'd5, 3'd5, 3'd5}, 3'b111);
		// r6 commits and is claimed again by tag 5 in one cycle
		add_row("queue and commit", {IDLE, IDLE, qs(1, 0, 6)},
			{sr(0, 0), sr(0, 0), sr(6, 0)},
			{NC, NC, cm(1, 1, 0, 6)}, 1'b0, '0, ~(bit_of(6) | bit_of(32)),
			~bit_of(32), {3'd6, 3'd6, 3'd5}, 3'b111);
		add_row("status commit", {IDLE, IDLE, IDLE}, '0,
			{NC, cm(5, 1, 0, 6), cm(2, 0, 1, 0)}, 1'b0, '0, ~(bit_of(6) | bit_of(32)),
			ALLV, {3'd6, 3'd6, 3'd6}, 3'b111);
		add_row("tag wrap", {qs(0, 1, 0), qs(1, 0, 11), qs(1, 0, 10)}, '0,
			{NC, NC, NC}, 1'b0, '0, ALLV, ALLV, {3'd0, 3'd7, 3'd6}, 3'b111);
		// only r11 has a surviving producer and the slots queued here are squashed
		add_row("branch miss", {IDLE, qs(1, 0, 13), qs(1, 0, 12)},
			{sr(0, 0), sr(11, 0), sr(10, 12)},
			{NC, NC, NC}, 1'b1, bit_of(11), ~(bit_of(10) | bit_of(11) | bit_of(32)),
			~bit_of(11), {3'd3, 3'd2, 3'd1}, 3'b101);
		add_row("tail held", {IDLE, IDLE, qs(1, 0, 12)}, {sr(0, 0), sr(0, 0), sr(11, 11)},
			{NC, NC, cm(7, 1, 0, 11)}, 1'b0, '0, ~bit_of(11), ALLV,
			{3'd2, 3'd2, 3'd1}, 3'b111);
		add_row("r0 claimed", {IDLE, IDLE, qs(1, 0, 0)}, {sr(0, 0), sr(12, 0), sr(0, 12)},
			{NC, NC, NC}, 1'b0, '0, ~bit_of(12), ~bit_of(12), {3'd3, 3'd3, 3'd2}, 3'b100);
		add_row("r0 ready", {IDLE, IDLE, IDLE}, {sr(12, 0), sr(0, 12), sr(0, 0)},
			{NC, NC, NC}, 1'b0, '0, ~(bit_of(0) | bit_of(12)),
			~(bit_of(0) | bit_of(12)), {3'd3, 3'd3, 3'd3}, 3'b001);
		add_row("two ports", {IDLE, IDLE, IDLE}, {sr(0, 0), sr(12, 12), sr(0, 0)},
			{NC, cm(2, 1, 0, 0), cm(1, 1, 0, 12)}, 1'b0, '0, ~(bit_of(0) | bit_of(12)),
			ALLV, {3'd3, 3'd3, 3'd3}, 3'b111);

		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// the model follows the directed rows so the random phase starts in step
		for (int k = 0; k < rows.size(); k++) begin
			@(negedge clk);
			drive_row(rows[k]);
			#1;
			check_outputs(names[k], rows[k]);
			model_edge(slots, commits, branchmiss, livetarget);
		end

		// random rows on registers 0..7 so that producers and commits collide often
		for (int n = 0; n < RAND_CYCLES; n++) begin
			@(negedge clk);
			for (int i = 0; i < QSLOTS; i++) begin
				r.slots[i] = '{1'(take_bits(1)), 1'(take_bits(1)), 1'(take_bits(1)),
					reg_idx_t'(take_bits(3))};
				r.srcs[i] = '{reg_idx_t'(take_bits(3)), reg_idx_t'(take_bits(3))};
			end
			for (int p = 0; p < CSLOTS; p++) begin
				r.commits[p] = '{1'(take_bits(1)), rob_tag_t'(take_bits(3)),
					1'(take_bits(1)), 1'(take_bits(1)), reg_idx_t'(take_bits(3))};
				// about half the commits carry the tag the table holds for the target
				if (take_bits(1)) begin
					r.commits[p].tag = r.commits[p].srw ? m_tag[AREGS] : m_tag[r.commits[p].tgt];
				end
			end
			r.bm = (take_bits(3) == 7);
			r.live = '0;
			r.live[7:0] = 8'(take_bits(8));
			r.live[AREGS] = 1'(take_bits(1));
			r.exp_valid = m_valid;
			r.exp_adv = model_adv(r.commits, r.bm, r.live);
			r.exp_tags = model_tags(r.slots);
			r.exp_ready = model_ready(r.srcs, r.exp_adv);
			drive_row(r);
			#1;
			check_outputs($sformatf("random %0d", n), r);
			model_edge(slots, commits, branchmiss, livetarget);
		end

		@(negedge clk);
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

/* verilog/rename_status_top.sv */
// rename status scoreboard

`timescale 1ns/1ps

module rename_status_top import rename_pkg::*; (
	input  logic                     clk,
	input  logic                     rst,
	input  slot_req_t [QSLOTS-1:0]   slots,
	input  slot_src_t [QSLOTS-1:0]   srcs,
	input  commit_t   [CSLOTS-1:0]   commits,
	input  logic                     branchmiss,
	input  reg_vec_t                 livetarget,
	output slot_tags_t               slot_tags,
	output reg_vec_t                 reg_valid,
	output reg_vec_t                 reg_is_valid,
	output logic      [QSLOTS-1:0]   ops_ready
);

	// latest producer tag of every register, from the table to the tracker
	src_tag_t [AREGS:0] sources;

	// ========================================
	// allocation and rename
	// ========================================

	// tags go to the table here and leave the top for the reorder buffer
	rob_tag_alloc rob_tag_alloc_inst (
		.clk        (clk),
		.rst        (rst),
		.branchmiss (branchmiss),
		.slots      (slots),
		.slot_tags  (slot_tags)
	);

	reg_source_table reg_source_table_inst (
		.clk        (clk),
		.rst        (rst),
		.branchmiss (branchmiss),
		.slots      (slots),
		.slot_tags  (slot_tags),
		.sources    (sources)
	);

	// ========================================
	// valid tracking and wakeup
	// ========================================

	reg_valid_tracker reg_valid_tracker_inst (
		.clk          (clk),
		.rst          (rst),
		.branchmiss   (branchmiss),
		.livetarget   (livetarget),
		.commits      (commits),
		.slots        (slots),
		.sources      (sources),
		.reg_valid    (reg_valid),
		.reg_is_valid (reg_is_valid)
	);

	// readiness works off the advanced vector, not the registered one
	operand_ready operand_ready_inst (
		.srcs         (srcs),
		.reg_is_valid (reg_is_valid),
		.ops_ready    (ops_ready)
	);

endmodule

/* verilog/operand_ready.sv */
// operand readiness

`timescale 1ns/1ps

module operand_ready import rename_pkg::*; (
	input  slot_src_t [QSLOTS-1:0]   srcs,
	input  reg_vec_t                 reg_is_valid,
	output logic      [QSLOTS-1:0]   ops_ready
);

	// per-operand readiness of each slot
	logic [QSLOTS-1:0] rs1_ready;
	logic [QSLOTS-1:0] rs2_ready;

	// ========================================
	// operand lookup
	// ========================================

	// the advanced vector is used so a commit in this cycle
	// wakes a waiting slot at once
	// register 0 reads as constant zero and never waits on a producer
	always_comb begin
		for (int i = 0; i < QSLOTS; i++) begin
			rs1_ready[i] = (srcs[i].rs1 == '0) || reg_is_valid[srcs[i].rs1];
			rs2_ready[i] = (srcs[i].rs2 == '0) || reg_is_valid[srcs[i].rs2];
		end
	end

	// a slot can go once both operands are available
	// slots with a single source name register 0 for the other one
	assign ops_ready = rs1_ready & rs2_ready;

endmodule

/* verilog/reg_valid_tracker.sv */
// register valid tracker

`timescale 1ns/1ps

module reg_valid_tracker import rename_pkg::*; (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     branchmiss,
	input  reg_vec_t                 livetarget,
	input  commit_t   [CSLOTS-1:0]   commits,
	input  slot_req_t [QSLOTS-1:0]   slots,
	input  src_tag_t  [AREGS:0]      sources,
	output reg_vec_t                 reg_valid,
	output reg_vec_t                 reg_is_valid
);

	// registers the queueing slots are about to claim this cycle
	reg_vec_t queue_clr;

	// a commit only counts if the table still names it as the producer
	// a younger instruction writing the same register has replaced the tag
	function automatic logic tag_match(input src_tag_t src, input rob_tag_t tag);
		return src.pending && (src.tag == tag);
	endfunction

	// ========================================
	// advanced valid vector
	// ========================================

	// this is the next-state value without the queue term, so a read-through
	// register file sees this cycle's commits without waiting for the edge
	always_comb begin
		reg_is_valid = reg_valid;

		// squashed work no longer owns any register that nothing live targets
		// the status bit is handled the same way through livetarget[AREGS]
		if (branchmiss) begin
			reg_is_valid = reg_is_valid | ~livetarget;
		end

		// commits are looked at in port order, a later port overrides an
		// earlier one on the same register
		// only registers that are invalid in the registered vector take part
		for (int c = 0; c < CSLOTS; c++) begin
			if (commits[c].valid && commits[c].rfw && !reg_valid[commits[c].tgt]) begin
				reg_is_valid[commits[c].tgt] =
					tag_match(sources[commits[c].tgt], commits[c].tag);
			end
			if (commits[c].valid && commits[c].srw && !reg_valid[AREGS]) begin
				reg_is_valid[AREGS] = tag_match(sources[AREGS], commits[c].tag);
			end
		end
	end

	// ========================================
	// queue invalidations
	// ========================================

	// nothing queued during a branch miss survives, so it claims nothing
	always_comb begin
		queue_clr = '0;
		if (!branchmiss) begin
			for (int i = 0; i < QSLOTS; i++) begin
				if (slots[i].valid && slots[i].rfw) begin
					queue_clr[slots[i].rd] = 1'b1;
				end
				if (slots[i].valid && slots[i].srw) begin
					queue_clr[AREGS] = 1'b1;
				end
			end
		end
	end

	// ========================================
	// registered valid vector
	// ========================================

	// a register queued on in the same cycle as a commit stays invalid,
	// since the new producer has not run yet
	always_ff @(posedge clk) begin
		if (rst) begin
			reg_valid <= '1;
		end else begin
			reg_valid <= reg_is_valid & ~queue_clr;
		end
	end

	// the advanced vector may only add valid bits, never take one away
	a_adv_keeps_valid: assert property (
		@(posedge clk) disable iff (rst)
		(reg_is_valid & reg_valid) == reg_valid
	) else $error("advanced vector cleared a valid register");

	// coming out of reset every register holds its architectural value
	a_reset_all_valid: assert property (
		@(posedge clk)
		rst |=> (reg_valid == '1)
	) else $error("valid vector not all ones after reset");

endmodule

/* verilog/reg_source_table.sv */
// register source table

`timescale 1ns/1ps

module reg_source_table import rename_pkg::*; (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     branchmiss,
	input  slot_req_t [QSLOTS-1:0]   slots,
	input  slot_tags_t               slot_tags,
	output src_tag_t  [AREGS:0]      sources
);

	// entry each queueing slot would record
	src_tag_t [QSLOTS-1:0] new_entry;

	// register write and status write strobes per slot
	logic [QSLOTS-1:0] rf_wr;
	logic [QSLOTS-1:0] sr_wr;

	// ========================================
	// write decode
	// ========================================

	// a slot only records a producer when it is really queued
	// nothing queued during a branch miss survives, so it records nothing
	always_comb begin
		for (int i = 0; i < QSLOTS; i++) begin
			new_entry[i].pending = 1'b1;
			new_entry[i].tag     = slot_tags[i];
			rf_wr[i] = slots[i].valid && slots[i].rfw && !branchmiss;
			sr_wr[i] = slots[i].valid && slots[i].srw && !branchmiss;
		end
	end

	// ========================================
	// table update
	// ========================================

	// slots are walked in ascending order, so for two slots naming the
	// same register the higher slot's nonblocking write lands last
	// this matches program order since the higher slot is the younger one
	always_ff @(posedge clk) begin
		if (rst) begin
			// every entry starts free with no producer on record
			sources <= '0;
		end else begin
			for (int i = 0; i < QSLOTS; i++) begin
				if (rf_wr[i]) begin
					sources[slots[i].rd] <= new_entry[i];
				end
				// the status register has one entry shared by all slots
				if (sr_wr[i]) begin
					sources[AREGS] <= new_entry[i];
				end
			end
		end
	end

	// commits never touch the table
	// a register only goes valid again when its recorded tag commits,
	// so leaving the entry in place is enough to tell stale commits apart

endmodule

/* verilog/rob_tag_alloc.sv */
// reorder tag allocator

`timescale 1ns/1ps

module rob_tag_alloc import rename_pkg::*; (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     branchmiss,
	input  slot_req_t [QSLOTS-1:0]   slots,
	output slot_tags_t               slot_tags
);

	// next free reorder entry
	rob_tag_t tail;

	// number of valid slots below the one being looked at
	rob_tag_t offset;

	// ========================================
	// tag assignment
	// ========================================

	// each slot takes the tail plus the count of valid slots below it
	// so valid slots get consecutive tags in slot order
	always_comb begin
		offset = '0;
		for (int i = 0; i < QSLOTS; i++) begin
			slot_tags[i] = rob_tag_t'(tail + offset);
			if (slots[i].valid) begin
				offset = rob_tag_t'(offset + 1'b1);
			end
		end
	end

	// ========================================
	// tail pointer
	// ========================================

	// after the loop offset holds the population count of the valid slots
	// the tag width matches RENTRIES so the sum wraps on its own
	always_ff @(posedge clk) begin
		if (rst) begin
			tail <= '0;
		end else if (!branchmiss) begin
			tail <= rob_tag_t'((tail + offset) % RENTRIES);
		end
	end

	// slots without their valid bit hand out nothing
	// so an idle cycle or a branch miss leaves the tail where it was
	a_idle_holds_tail: assert property (
		@(posedge clk) disable iff (rst)
		(branchmiss || !(slots[0].valid || slots[1].valid || slots[2].valid))
			|=> $stable(tail)
	) else $error("tail moved without a valid slot");

endmodule

/* verilog/rename_pkg.sv */
// rename status shared definitions

package rename_pkg;

	// ========================================
	// sizes
	// ========================================

	// architectural registers, the status register sits at index AREGS
	localparam int AREGS = 32;

	// instructions queued per cycle
	localparam int QSLOTS = 3;

	// commit ports per cycle
	localparam int CSLOTS = 3;

	// reorder entries, a tag names one of them
	localparam int RENTRIES = 8;

	// the tag is just wide enough to count the reorder entries
	localparam int TAG_W = $clog2(RENTRIES);

	// ========================================
	// index types
	// ========================================

	typedef logic [4:0] reg_idx_t;

	typedef logic [TAG_W-1:0] rob_tag_t;

	// one valid bit per register, the top bit is the status register
	typedef logic [AREGS:0] reg_vec_t;

	// latest producer of a register
	// pending stays set once any producer has been recorded
	typedef struct packed {
		logic     pending;
		rob_tag_t tag;
	} src_tag_t;

	// ========================================
	// per-slot and per-port bundles
	// ========================================

	// one queueing slot and what it will write
	typedef struct packed {
		logic     valid;
		logic     rfw;
		logic     srw;
		reg_idx_t rd;
	} slot_req_t;

	// source operands of a queueing slot
	typedef struct packed {
		reg_idx_t rs1;
		reg_idx_t rs2;
	} slot_src_t;

	// one commit port
	// tgt is only meaningful with rfw, srw targets the status register
	typedef struct packed {
		logic     valid;
		rob_tag_t tag;
		logic     rfw;
		logic     srw;
		reg_idx_t tgt;
	} commit_t;

	// tags handed to the slots, slot 0 in the low bits
	typedef rob_tag_t [QSLOTS-1:0] slot_tags_t;

endpackage
